/* logic/game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// tree lanes across the playfield
`define GAME_NUM_LANES 16

`define GAME_MAX_LEVEL 8

// wave periods in frames, reduced by the level speed
`define GAME_TREE_PERIOD_BASE 8
`define GAME_BIRD_PERIOD_BASE 4

`endif

/* logic/game_pkg.sv */
`include "game_defs.svh"

package game_pkg;

	typedef struct packed {
		logic [`GAME_NUM_LANES-1:0] tree_mask; // one bit per lane
		logic [2:0] tree_speed;
		logic [1:0] bird_speed;
		logic [1:0] num_birds;
		logic [3:0] bird_life;
	} level_profile_t;

	// two-digit decimal level for the score display
	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] ones;
	} level_bcd_t;

	typedef struct packed {
		logic [3:0] lane;
		logic [2:0] speed;
		logic [3:0] spare; // keeps both views at 11 bits
	} tree_spawn_t;

	typedef struct packed {
		logic [1:0] index;
		logic [1:0] speed;
		logic [3:0] life;
		logic [2:0] spare;
	} bird_spawn_t;

	// decoded by kind
	typedef union packed {
		tree_spawn_t tree;
		bird_spawn_t bird;
	} spawn_payload_u;

	typedef enum logic {
		SPAWN_TREE = 1'b0,
		SPAWN_BIRD = 1'b1
	} spawn_kind_e;

	typedef struct packed {
		spawn_kind_e kind;
		spawn_payload_u payload;
	} spawn_cmd_t;

endpackage

/* logic/level_sequencer.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module level_sequencer (
	input logic clk,
	input logic resetN,
	input logic level_up,
	output game_pkg::level_profile_t profile,
	output game_pkg::level_bcd_t level_num
);

	enum logic [2:0] {
		LEVEL_1,
		LEVEL_2,
		LEVEL_3,
		LEVEL_4,
		LEVEL_5,
		LEVEL_6,
		LEVEL_7,
		LEVEL_8
	} level, next_level;

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			level <= LEVEL_1;
			level_num.tens <= 4'd0;
			level_num.ones <= 4'd1; // display starts at 01
		end
		else
		begin
			level <= next_level;
			if (level_up)
			begin
				if (level_num.ones == 4'd9)
				begin
					level_num.ones <= 4'd0;
					// 99 wraps to 00
					if (level_num.tens == 4'd9)
						level_num.tens <= 4'd0;
					else
						level_num.tens <= level_num.tens + 4'd1;
				end
				else
					level_num.ones <= level_num.ones + 4'd1;
			end
		end
	end

	// stop at the top level
	always_comb
	begin
		next_level = level;
		if (level_up && (int'(level) < `GAME_MAX_LEVEL - 1))
			next_level = level.next();
	end

	// difficulty table: mask, tree speed, bird speed, birds, life
	always_comb
	begin
		case (level)
			LEVEL_1:
				profile = '{16'h0101, 3'd0, 2'd0, 2'd0, 4'd3}; // lanes 0 and 8
			LEVEL_2:
				profile = '{16'h1111, 3'd1, 2'd1, 2'd0, 4'd3};
			LEVEL_3:
				profile = '{16'h1515, 3'd2, 2'd1, 2'd1, 4'd4}; // first bird
			LEVEL_4:
				profile = '{16'h5555, 3'd3, 2'd2, 2'd1, 4'd4};
			LEVEL_5:
				profile = '{16'hD5D5, 3'd4, 2'd2, 2'd2, 4'd5};
			LEVEL_6:
				profile = '{16'hDDDD, 3'd5, 2'd2, 2'd2, 4'd5};
			LEVEL_7:
				profile = '{16'hDFDF, 3'd6, 2'd3, 2'd3, 4'd6};
			default:
				profile = '{16'hFFFF, 3'd7, 2'd3, 2'd3, 4'd7}; // every lane
		endcase
	end

	a_bcd_digits: assert property (@(posedge clk) disable iff (!resetN)
		level_num.tens <= 4'd9 && level_num.ones <= 4'd9)
		else $error("level_num digit out of BCD range");

endmodule

/* logic/tree_spawner.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module tree_spawner (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input game_pkg::level_profile_t profile,
	output logic tree_valid,
	output game_pkg::tree_spawn_t tree,
	input logic tree_ready
);

	logic [3:0] frame_cnt;
	logic [3:0] tree_period;
	logic wave_start;
	logic [`GAME_NUM_LANES-1:0] pending; // lanes still to emit
	logic [2:0] speed_q;
	logic [3:0] lane_sel;

	assign tree_period = 4'(`GAME_TREE_PERIOD_BASE) - {1'b0, profile.tree_speed};
	assign wave_start = start_of_frame && (frame_cnt + 4'd1 >= tree_period);

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			frame_cnt <= '0;
			pending <= '0;
		end
		else
		begin
			if (wave_start)
				frame_cnt <= '0;
			else if (start_of_frame)
				frame_cnt <= frame_cnt + 4'd1;

			// a start during a busy wave is dropped
			if (wave_start && !tree_valid)
				pending <= profile.tree_mask;
			else if (tree_valid && tree_ready)
				pending[lane_sel] <= 1'b0;
		end
	end

	// speed is frozen for the whole wave
	always_ff @(posedge clk)
	begin
		if (wave_start && !tree_valid)
			speed_q <= profile.tree_speed;
	end

	// lowest remaining lane wins
	always_comb
	begin
		lane_sel = '0;
		for (int i = `GAME_NUM_LANES - 1; i >= 0; i--)
		begin
			if (pending[i])
				lane_sel = 4'(i);
		end
	end

	assign tree_valid = |pending;
	assign tree.lane = lane_sel;
	assign tree.speed = speed_q;
	assign tree.spare = '0;

	a_tree_stable: assert property (@(posedge clk) disable iff (!resetN)
		tree_valid && !tree_ready |=> tree_valid && $stable(tree))
		else $error("tree event changed while stalled");

endmodule

/* logic/bird_spawner.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module bird_spawner (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input game_pkg::level_profile_t profile,
	output logic bird_valid,
	output game_pkg::bird_spawn_t bird,
	input logic bird_ready
);

	logic [2:0] frame_cnt;
	logic [2:0] bird_period;
	logic wave_start;
	logic busy;
	logic [1:0] idx;
	logic [1:0] count_q; // birds in this wave
	logic [1:0] speed_q;
	logic [3:0] life_q;

	assign bird_period = 3'(`GAME_BIRD_PERIOD_BASE) - {1'b0, profile.bird_speed};
	assign wave_start = start_of_frame && (frame_cnt + 3'd1 >= bird_period);

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			frame_cnt <= '0;
			busy <= 1'b0;
			idx <= '0;
		end
		else
		begin
			if (wave_start)
				frame_cnt <= '0;
			else if (start_of_frame)
				frame_cnt <= frame_cnt + 3'd1;

			if (wave_start && !busy && profile.num_birds != 2'd0)
			begin
				busy <= 1'b1;
				idx <= '0;
			end
			else if (busy && bird_ready)
			begin
				if (idx + 2'd1 == count_q)
					busy <= 1'b0; // last bird handed over
				else
					idx <= idx + 2'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wave_start && !busy)
		begin
			count_q <= profile.num_birds;
			speed_q <= profile.bird_speed;
			life_q <= profile.bird_life;
		end
	end

	assign bird_valid = busy;
	assign bird.index = idx;
	assign bird.speed = speed_q;
	assign bird.life = life_q;
	assign bird.spare = '0;

	a_bird_index: assert property (@(posedge clk) disable iff (!resetN)
		bird_valid |-> idx < count_q)
		else $error("bird index past wave count");

endmodule

/* logic/spawn_arbiter.sv */
`timescale 1ns/1ps

module spawn_arbiter (
	input logic clk,
	input logic resetN,
	input logic tree_valid,
	input game_pkg::tree_spawn_t tree,
	output logic tree_ready,
	input logic bird_valid,
	input game_pkg::bird_spawn_t bird,
	output logic bird_ready,
	output logic cmd_valid,
	output game_pkg::spawn_cmd_t cmd,
	input logic cmd_ready
);

	logic can_accept;
	logic rr_bird; // bird has priority on next contention
	logic contend;

	// one slot, refilled on the cycle it drains
	assign can_accept = !cmd_valid || cmd_ready;
	assign contend = tree_valid && bird_valid;

	assign tree_ready = can_accept && tree_valid && (!bird_valid || !rr_bird);
	assign bird_ready = can_accept && bird_valid && (!tree_valid || rr_bird);

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			cmd_valid <= 1'b0;
			rr_bird <= 1'b0;
		end
		else
		begin
			if (tree_ready || bird_ready)
				cmd_valid <= 1'b1;
			else if (cmd_ready)
				cmd_valid <= 1'b0;

			if (contend && can_accept)
				rr_bird <= !rr_bird;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tree_ready)
		begin
			cmd.kind <= game_pkg::SPAWN_TREE;
			cmd.payload.tree <= tree;
		end
		else if (bird_ready)
		begin
			cmd.kind <= game_pkg::SPAWN_BIRD;
			cmd.payload.bird <= bird;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!resetN)
		!(tree_ready && bird_ready))
		else $error("both spawners granted at once");

endmodule

/* logic/game_level_top.sv */
`timescale 1ns/1ps

module game_level_top (
	input logic clk,
	input logic resetN,
	input logic level_up,
	input logic start_of_frame,
	input logic cmd_ready,
	output logic cmd_valid,
	output game_pkg::spawn_cmd_t cmd,
	output game_pkg::level_bcd_t level_num,
	output game_pkg::level_profile_t profile
);

	logic tree_valid;
	logic tree_ready;
	game_pkg::tree_spawn_t tree;
	logic bird_valid;
	logic bird_ready;
	game_pkg::bird_spawn_t bird;

	level_sequencer u_level_sequencer (
		.clk (clk),
		.resetN (resetN),
		.level_up (level_up),
		.profile (profile),
		.level_num (level_num)
	);

	tree_spawner u_tree_spawner (
		.clk (clk),
		.resetN (resetN),
		.start_of_frame (start_of_frame),
		.profile (profile),
		.tree_valid (tree_valid),
		.tree (tree),
		.tree_ready (tree_ready)
	);

	bird_spawner u_bird_spawner (
		.clk (clk),
		.resetN (resetN),
		.start_of_frame (start_of_frame),
		.profile (profile),
		.bird_valid (bird_valid),
		.bird (bird),
		.bird_ready (bird_ready)
	);

	spawn_arbiter u_spawn_arbiter (
		.clk (clk),
		.resetN (resetN),
		.tree_valid (tree_valid),
		.tree (tree),
		.tree_ready (tree_ready),
		.bird_valid (bird_valid),
		.bird (bird),
		.bird_ready (bird_ready),
		.cmd_valid (cmd_valid),
		.cmd (cmd),
		.cmd_ready (cmd_ready)
	);

endmodule

/* dv/game_level_checks.svh */
`ifndef GAME_LEVEL_CHECKS_SVH
`define GAME_LEVEL_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic note_failure(input string what);
	$display("error at %0t: %s", $time, what);
	error_count++;
endtask

task automatic mismatch(input string name, input logic [31:0] expected, input logic [31:0] actual);
	$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
	error_count++;
endtask

task automatic check_profile(input string name, input game_pkg::level_profile_t expected,
	input game_pkg::level_profile_t actual);
	check_count++;
	if (actual !== expected)
		mismatch(name, 32'(expected), 32'(actual));
endtask

task automatic check_bcd(input string name, input game_pkg::level_bcd_t expected,
	input game_pkg::level_bcd_t actual);
	check_count++;
	if (actual !== expected)
		mismatch(name, 32'(expected), 32'(actual));
endtask

task automatic check_cmd(input string name, input game_pkg::spawn_cmd_t expected,
	input game_pkg::spawn_cmd_t actual);
	check_count++;
	if (actual !== expected)
		mismatch(name, 32'(expected), 32'(actual));
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	check_count++;
	if (actual !== expected)
		mismatch(name, 32'(expected), 32'(actual));
endtask

`endif

/* dv/game_level_tb.sv */
`timescale 1ns/1ps
`include "game_defs.svh"

module game_level_tb;

	`include "game_level_checks.svh"

	logic clk;
	logic resetN;
	logic level_up;
	logic start_of_frame;
	logic cmd_ready;
	logic cmd_valid;
	game_pkg::spawn_cmd_t cmd;
	game_pkg::level_bcd_t level_num;
	game_pkg::level_profile_t profile;

	game_pkg::spawn_cmd_t seen_q[$]; // transfers in arrival order
	game_pkg::spawn_cmd_t held_cmd;
	logic random_ready;
	logic stalled;
	logic [15:0] lfsr;
	int tests_run = 0;

	game_level_top u_game_level_top (
		.clk (clk),
		.resetN (resetN),
		.level_up (level_up),
		.start_of_frame (start_of_frame),
		.cmd_ready (cmd_ready),
		.cmd_valid (cmd_valid),
		.cmd (cmd),
		.level_num (level_num),
		.profile (profile)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// sprite engine model picking ready for the next rising edge
	initial
	begin
		logic ready_next;
		cmd_ready = 1'b0;
		random_ready = 1'b0;
		stalled = 1'b0;
		held_cmd = '0;
		lfsr = 16'd96;
		@(posedge clk);
		forever
		begin
			@(negedge clk);
			if (stalled)
			begin
				check_bit("cmd_valid", 1'b1, cmd_valid); // must hold through the stall
				check_cmd("cmd", held_cmd, cmd);
			end
			if (random_ready)
			begin
				lfsr = lfsr_step(lfsr);
				ready_next = lfsr[0];
			end
			else
				ready_next = 1'b1;
			cmd_ready = ready_next;
			if (cmd_valid && ready_next)
				seen_q.push_back(cmd);
			stalled = cmd_valid && !ready_next;
			held_cmd = cmd;
		end
	end

	// mask, tree speed, bird speed, birds, life
	function automatic game_pkg::level_profile_t table_row(input int level);
		case (level)
			1: return '{16'h0101, 3'd0, 2'd0, 2'd0, 4'd3};
			2: return '{16'h1111, 3'd1, 2'd1, 2'd0, 4'd3};
			3: return '{16'h1515, 3'd2, 2'd1, 2'd1, 4'd4};
			4: return '{16'h5555, 3'd3, 2'd2, 2'd1, 4'd4};
			5: return '{16'hD5D5, 3'd4, 2'd2, 2'd2, 4'd5};
			6: return '{16'hDDDD, 3'd5, 2'd2, 2'd2, 4'd5};
			7: return '{16'hDFDF, 3'd6, 2'd3, 2'd3, 4'd6};
			default: return '{16'hFFFF, 3'd7, 2'd3, 2'd3, 4'd7};
		endcase
	endfunction

	function automatic game_pkg::level_bcd_t bcd_of(input int value);
		game_pkg::level_bcd_t bcd;
		bcd.tens = 4'((value / 10) % 10);
		bcd.ones = 4'(value % 10);
		return bcd;
	endfunction

	function automatic game_pkg::spawn_cmd_t tree_cmd(input int lane, input logic [2:0] speed);
		game_pkg::spawn_cmd_t c;
		c = '0;
		c.kind = game_pkg::SPAWN_TREE;
		c.payload.tree.lane = 4'(lane);
		c.payload.tree.speed = speed;
		return c;
	endfunction

	function automatic game_pkg::spawn_cmd_t bird_cmd(input int index, input logic [1:0] speed,
		input logic [3:0] life);
		game_pkg::spawn_cmd_t c;
		c = '0;
		c.kind = game_pkg::SPAWN_BIRD;
		c.payload.bird.index = 2'(index);
		c.payload.bird.speed = speed;
		c.payload.bird.life = life;
		return c;
	endfunction

	task automatic reset_dut(input logic use_lfsr);
		resetN = 1'b0;
		level_up = 1'b0;
		start_of_frame = 1'b0;
		@(posedge clk);
		random_ready = use_lfsr; // sink picks it up on the next falling edge
		@(negedge clk);
		@(negedge clk);
		resetN = 1'b1;
		seen_q.delete();
	endtask

	task automatic pulse_level_up();
		level_up = 1'b1;
		@(negedge clk);
		level_up = 1'b0;
	endtask

	// frame pulse plus a short blanking gap
	task automatic send_frame();
		start_of_frame = 1'b1;
		@(negedge clk);
		start_of_frame = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic wait_idle(input string name);
		int cycles;
		cycles = 0;
		repeat (2) @(negedge clk); // a wave just started needs two edges to show
		while (cmd_valid && cycles < 1000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cmd_valid)
			note_failure($sformatf("%s: command stream never went idle", name));
	endtask

	// split the stream by kind and match each against whole waves
	task automatic check_waves(input string name, input game_pkg::level_profile_t row,
		output int trees, output int birds, output bit bird_mid_wave);
		int lanes[$];
		int nb;
		nb = int'(row.num_birds);
		trees = 0;
		birds = 0;
		bird_mid_wave = 1'b0;
		for (int i = 0; i < `GAME_NUM_LANES; i++)
		begin
			if (row.tree_mask[i])
				lanes.push_back(i);
		end
		foreach (seen_q[i])
		begin
			if (seen_q[i].kind == game_pkg::SPAWN_TREE)
			begin
				check_cmd("cmd", tree_cmd(lanes[trees % lanes.size()], row.tree_speed), seen_q[i]);
				trees++;
			end
			else if (nb == 0)
				note_failure($sformatf("%s: bird command at a level without birds", name));
			else
			begin
				check_cmd("cmd", bird_cmd(birds % nb, row.bird_speed, row.bird_life), seen_q[i]);
				birds++;
				if (trees % lanes.size() != 0)
					bird_mid_wave = 1'b1; // merged into a running tree wave
			end
		end
		if (trees % lanes.size() != 0 || (nb != 0 && birds % nb != 0))
			note_failure($sformatf("%s: a wave arrived incomplete", name));
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("test %0d, %s: %0d errors", tests_run, name, error_count - errors_before);
	endtask

	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		reset_dut(1'b0);
		check_profile("profile", table_row(1), profile);
		check_bcd("level_num", bcd_of(1), level_num);
		check_bit("cmd_valid", 1'b0, cmd_valid);
		report_test("reset state", errors_before);
	endtask

	task automatic test_levels();
		int errors_before;
		errors_before = error_count;
		reset_dut(1'b0);
		for (int n = 0; n <= 9; n++)
		begin
			if (n > 0)
				pulse_level_up();
			check_profile("profile", table_row(n + 1 > 8 ? 8 : n + 1), profile);
		end
		report_test("level progression", errors_before);
	endtask

	task automatic test_level_number();
		int errors_before;
		errors_before = error_count;
		reset_dut(1'b0);
		for (int k = 0; k <= 100; k++) // through 09 to 10 and 99 to 00
		begin
			if (k > 0)
				pulse_level_up();
			check_bcd("level_num", bcd_of((k + 1) % 100), level_num);
		end
		report_test("decimal level number", errors_before);
	endtask

	task automatic test_tree_wave();
		int errors_before;
		int frames;
		int trees;
		int birds;
		bit mid_wave;
		errors_before = error_count;
		reset_dut(1'b0);
		frames = 0;
		while (seen_q.size() < 2 && frames < 20)
		begin
			send_frame();
			frames++;
		end
		if (seen_q.size() < 2)
			note_failure("no tree wave after 20 frames at level 1");
		wait_idle("tree wave");
		check_waves("tree wave", table_row(1), trees, birds, mid_wave);
		if (trees != 2 || birds != 0)
			note_failure($sformatf("level 1 gave %0d trees and %0d birds", trees, birds));
		report_test("tree wave at level 1", errors_before);
	endtask

	task automatic test_mixed_waves(input logic use_lfsr, input string name);
		int errors_before;
		int trees;
		int birds;
		bit mid_wave;
		errors_before = error_count;
		reset_dut(use_lfsr);
		repeat (6) pulse_level_up();
		check_profile("profile", table_row(7), profile);
		repeat (6) send_frame();
		wait_idle(name);
		check_waves(name, table_row(7), trees, birds, mid_wave);
		if (trees == 0 || birds == 0)
			note_failure($sformatf("%s: only one kind of command arrived", name));
		if (!mid_wave)
			note_failure($sformatf("%s: no bird command inside a tree wave", name));
		report_test(name, errors_before);
	endtask

	initial
	begin
		resetN = 1'b0;
		level_up = 1'b0;
		start_of_frame = 1'b0;
		@(posedge clk);
		@(negedge clk);
		test_reset();
		test_levels();
		test_level_number();
		test_tree_wave();
		test_mixed_waves(1'b0, "mixed waves at level 7");
		test_mixed_waves(1'b1, "mixed waves with back-pressure");
		$display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+logic
+incdir+dv
logic/game_pkg.sv
logic/level_sequencer.sv
logic/tree_spawner.sv
logic/bird_spawner.sv
logic/spawn_arbiter.sv
logic/game_level_top.sv
dv/game_level_tb.sv

/* Makefile */
all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module game_level_tb \
		-Mdir obj_dir -o game_level_sim

run: compile
	./obj_dir/game_level_sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
